/* forney.f */
gf_pkg.sv
forney_pkg.sv
gf_mult.sv
poly_eval.sv
gf_fermat_div.sv
forney_unit.sv
forney_asserts.sv
forney_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= forney_tb
FILELIST ?= forney.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert
RUN_ARGS ?= +verilator+error+limit+1000
PASS_MSG ?= TEST RESULT: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* forney_tb.sv */
`timescale 1ns/1ns

module forney_tb import gf_pkg::*, forney_pkg::*; ();

	localparam int SEED = 32'hdccd7d81;
	localparam int LATENCY = 12;            // Input transfer edge to output transfer edge.
	localparam int TIMEOUT = 2000;          // Cycles allowed for any single wait.

	logic clk = 1'b0;
	logic rst;
	logic in_valid;
	logic in_ready;
	gf_elem_t point;
	gf_elem_t omega_coef [OMEGA_N];
	gf_elem_t lambda_coef [LAMBDA_N];
	logic out_valid;
	logic out_ready;
	gf_elem_t magnitude;
	logic div_zero;

	int seed;
	int bp_seed = SEED;                     // Separate stream for out_ready.
	logic bp_on = 1'b0;                     // Random back-pressure enable.
	logic lat_on = 1'b0;                    // Latency check enable.
	logic timed_out = 1'b0;
	int cyc = 0;                            // Rising edges so far.
	int err_count = 0;
	int checked = 0;
	int tests = 0;
	int results;
	int test_errs;
	string test_name;
	gf_elem_t exp_mag [$];                  // Scoreboard with one entry per accepted request.
	logic exp_zero [$];
	int exp_cyc [$];

	forney_unit forney_unit_i (.*);

	always #4 clk = ~clk;                   // 8 ns period.

	always @(posedge clk) cyc <= cyc + 1;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Reference model.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Carry-less product, then long division by x^8 + x^4 + x^3 + x^2 + 1.
	function automatic gf_elem_t ref_mul(input gf_elem_t a, input gf_elem_t b);
		logic [14:0] prod;
		prod = '0;
		for (int i = 0; i < GF_M; i++) begin
			if (b[i]) prod = prod ^ ({7'b0, a} << i);       // Add shifted copy.
		end
		for (int i = 14; i >= GF_M; i--) begin
			if (prod[i]) prod = prod ^ ({7'b1, GF_POLY} << (i - GF_M));
		end
		return prod[GF_M-1:0];
	endfunction

	// d^254 is the inverse; zero stays zero.
	function automatic gf_elem_t ref_inv(input gf_elem_t d);
		gf_elem_t r;
		r = 8'h01;
		for (int i = 0; i < 254; i++) begin
			r = ref_mul(r, d);
		end
		return r;
	endfunction

	task automatic push_expected();
		gf_elem_t num;
		gf_elem_t den;
		num = omega_coef[OMEGA_N-1];                    // Horner from the top.
		for (int i = OMEGA_N - 2; i >= 0; i--) begin
			num = ref_mul(num, point) ^ omega_coef[i];
		end
		den = lambda_coef[0] ^ ref_mul(lambda_coef[1], ref_mul(point, point));
		exp_mag.push_back(ref_mul(num, ref_inv(den)));
		exp_zero.push_back(den == 8'h00);
		exp_cyc.push_back(cyc);
	endtask

	task automatic check_output();
		gf_elem_t mag;
		logic zero;
		int lat;
		results++;                                      // Every output transfer counts.
		if (exp_mag.size() == 0) begin
			$display("%s: output transfer with no request pending", test_name);
			err_count++;
		end else begin
			mag = exp_mag.pop_front();
			zero = exp_zero.pop_front();
			lat = cyc - exp_cyc.pop_front();
			checked++;
			if (magnitude !== mag) begin
				$display("ERR %s magnitude: expected %h, actual %h",
					test_name, mag, magnitude);
				err_count++;
			end
			if (div_zero !== zero) begin
				$display("ERR %s div_zero: expected %b, actual %b",
					test_name, zero, div_zero);
				err_count++;
			end
			if (lat_on && lat != LATENCY) begin
				$display("ERR %s latency: expected %0d, actual %0d", test_name, LATENCY, lat);
				err_count++;
			end
		end
	endtask

	// Sampled at mid-cycle. The next rising edge does the transfer.
	always @(negedge clk) begin
		if (!rst && in_valid && in_ready) push_expected();
		if (!rst && out_valid && out_ready) check_output();
	end

	// Output sink that stalls about half the cycles when enabled.
	initial begin
		logic [31:0] r;
		out_ready = 1'b1;
		forever begin
			@(posedge clk);
			#1;
			r = $random(bp_seed);
			out_ready = bp_on ? r[0] : 1'b1;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Driver tasks start and end 1 ns after a rising edge.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic idle(input int n);
		repeat (n) begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic randomize_inputs();
		logic [31:0] r;
		r = $random(seed);
		point = r[7:0];
		for (int i = 0; i < OMEGA_N; i++) begin
			r = $random(seed);
			omega_coef[i] = r[7:0];
		end
		for (int i = 0; i < LAMBDA_N; i++) begin
			r = $random(seed);
			lambda_coef[i] = r[7:0];
		end
	endtask

	// Hold keeps in_valid up so the caller can stream the next request.
	task automatic send_request(input logic hold);
		logic got;
		got = 1'b0;
		in_valid = 1'b1;
		for (int n = 0; n < TIMEOUT && !got; n++) begin
			@(negedge clk);
			got = in_ready;
			@(posedge clk);
			#1;
		end
		if (!got) begin
			$display("%s: timed out waiting for in_ready", test_name);
			timed_out = 1'b1;
			err_count++;
		end
		if (!hold || !got) in_valid = 1'b0;
	endtask

	task automatic wait_drain();
		int n;
		n = 0;
		while (exp_mag.size() != 0 && n < TIMEOUT && !timed_out) begin
			@(posedge clk);
			#1;
			n++;
		end
		if (exp_mag.size() != 0 && !timed_out) begin
			$display("%s: timed out waiting for %0d results", test_name, exp_mag.size());
			timed_out = 1'b1;
			err_count++;
		end
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_errs = err_count;
		results = 0;
		tests++;
	endtask

	task automatic report_test();
		$display("%s: %0d results, %0d errors", test_name, results, err_count - test_errs);
	endtask

	task automatic check_count(input int want);
		if (!timed_out && results != want) begin
			$display("%s: %0d results arrived for %0d requests", test_name, results, want);
			err_count++;
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Tests.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic single_requests();
		for (int k = 0; k < 20 && !timed_out; k++) begin
			randomize_inputs();
			send_request(1'b0);
			wait_drain();
		end
		check_count(20);
	endtask

	// Even k clears both terms and odd k sets lambda1 = lambda3 * x^2.
	task automatic zero_denominator();
		for (int k = 0; k < 10 && !timed_out; k++) begin
			randomize_inputs();
			if (k[0]) begin
				lambda_coef[0] = ref_mul(lambda_coef[1], ref_mul(point, point));
			end else begin
				lambda_coef[0] = 8'h00;
				lambda_coef[1] = 8'h00;
			end
			send_request(1'b0);
			wait_drain();
		end
		check_count(10);
	endtask

	task automatic edge_operands();
		for (int k = 0; k < 6 && !timed_out; k++) begin
			randomize_inputs();
			if (k % 3 == 0) begin
				point = 8'h00;                  // Result is omega0 / lambda1.
			end else if (k % 3 == 1) begin
				point = 8'h01;
			end else begin
				foreach (omega_coef[i]) omega_coef[i] = 8'hff;
				foreach (lambda_coef[i]) lambda_coef[i] = 8'hff;
			end
			send_request(1'b0);
			wait_drain();
		end
		check_count(6);
	endtask

	task automatic streaming();
		for (int k = 0; k < 200 && !timed_out; k++) begin
			randomize_inputs();
			send_request(k != 199);                 // in_valid stays high.
		end
		wait_drain();
		check_count(200);
	endtask

	task automatic backpressure();
		logic [31:0] r;
		bp_on = 1'b1;
		for (int k = 0; k < 100 && !timed_out; k++) begin
			r = $random(seed);
			idle(int'(r[1:0]));                     // Gap of 0 to 3 cycles.
			randomize_inputs();
			send_request(1'b0);
		end
		wait_drain();
		bp_on = 1'b0;
		check_count(100);
	endtask

	task automatic reset_midstream();
		for (int k = 0; k < 2 && !timed_out; k++) begin
			randomize_inputs();
			send_request(1'b0);
		end
		idle(3);                                        // Both items still in flight.
		rst = 1'b1;
		exp_mag.delete();
		exp_zero.delete();
		exp_cyc.delete();
		idle(8);
		rst = 1'b0;
		for (int n = 0; n < 30; n++) begin
			@(negedge clk);
			if (out_valid) begin
				$display("%s: output appeared after reset with no new input", test_name);
				err_count++;
			end
		end
		@(posedge clk);
		#1;
		randomize_inputs();
		send_request(1'b0);
		wait_drain();
		check_count(1);
	endtask

	initial begin
		seed = SEED;
		rst = 1'b1;
		in_valid = 1'b0;
		point = 8'h00;
		foreach (omega_coef[i]) omega_coef[i] = 8'h00;
		foreach (lambda_coef[i]) lambda_coef[i] = 8'h00;
		repeat (8) @(posedge clk);
		#1;
		rst = 1'b0;
		lat_on = 1'b1;                                  // Only unloaded single requests.
		start_test("single_requests");
		single_requests();
		report_test();
		start_test("zero_denominator");
		zero_denominator();
		report_test();
		start_test("edge_operands");
		edge_operands();
		report_test();
		lat_on = 1'b0;
		start_test("streaming");
		streaming();
		report_test();
		start_test("backpressure");
		backpressure();
		report_test();
		start_test("reset_midstream");
		reset_midstream();
		report_test();
		err_count += forney_unit_i.forney_asserts_i.fail_count;
		$display("tests %0d, results checked %0d, errors %0d, assertion failures %0d",
			tests, checked, err_count, forney_unit_i.forney_asserts_i.fail_count);
		if (err_count == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

/* forney_asserts.sv */
`timescale 1ns/1ns

module forney_asserts import gf_pkg::*; (
	input logic clk,
	input logic rst,
	input logic in_valid,
	input logic in_ready,
	input logic out_valid,
	input logic out_ready,
	input gf_elem_t magnitude,
	input logic div_zero
);

	int fail_count = 0;                     // Summed into the final error count.

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Output stage.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	out_cleared: assert property (@(posedge clk) rst |=> !out_valid)
	else begin
		$error("out_valid high in the cycle after reset");
		fail_count++;
	end

	// A stalled result keeps its value and flag.
	out_held: assert property (@(posedge clk) disable iff (rst)
		out_valid && !out_ready |=> out_valid && $stable(magnitude) && $stable(div_zero))
	else begin
		$error("result changed while out_ready was low");
		fail_count++;
	end

	zero_result: assert property (@(posedge clk) disable iff (rst)
		out_valid && div_zero |-> magnitude == '0)
	else begin
		$error("div_zero set with a nonzero magnitude");
		fail_count++;
	end

	// Both evaluators go busy on accept.
	in_busy: assert property (@(posedge clk) disable iff (rst)
		in_valid && in_ready |=> !in_ready)
	else begin
		$error("in_ready high right after an input transfer");
		fail_count++;
	end

endmodule

bind forney_unit forney_asserts forney_asserts_i (.*);

/* forney_unit.sv */
`timescale 1ns/1ns

module forney_unit import gf_pkg::*, forney_pkg::*; (
	input logic clk,
	input logic rst,
	input logic in_valid,
	output logic in_ready,
	input gf_elem_t point,                          // Inverted locator from Chien.
	input gf_elem_t omega_coef [OMEGA_N],           // Index 3 is the highest power.
	input gf_elem_t lambda_coef [LAMBDA_N],         // [1] lambda3, [0] lambda1.
	output logic out_valid,
	input logic out_ready,
	output gf_elem_t magnitude,
	output logic div_zero
);

	logic omega_in_ready;
	logic lambda_in_ready;
	logic num_valid;
	logic num_ready;
	gf_elem_t num;                                  // omega(x).
	logic den_valid;
	logic den_ready;
	gf_elem_t den;                                  // lambda'(x).

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Fan out, both evaluators take the request together.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign in_ready = omega_in_ready && lambda_in_ready;

	poly_eval #(.N_COEF(OMEGA_N), .SPACING(1)) omega_eval (
		.clk(clk),
		.rst(rst),
		.in_valid(in_valid && lambda_in_ready),  // Wait for the partner.
		.in_ready(omega_in_ready),
		.point(point),
		.coef(omega_coef),
		.out_valid(num_valid),
		.out_ready(num_ready),
		.result(num)
	);

	// Odd terms only, evaluated at x^2.
	poly_eval #(.N_COEF(LAMBDA_N), .SPACING(2)) lambda_eval (
		.clk(clk),
		.rst(rst),
		.in_valid(in_valid && omega_in_ready),
		.in_ready(lambda_in_ready),
		.point(point),
		.coef(lambda_coef),
		.out_valid(den_valid),
		.out_ready(den_ready),
		.result(den)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Division stage.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	gf_fermat_div div_unit (
		.clk(clk),
		.rst(rst),
		.num_valid(num_valid),
		.num_ready(num_ready),
		.num(num),
		.den_valid(den_valid),
		.den_ready(den_ready),
		.den(den),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.magnitude(magnitude),
		.div_zero(div_zero)
	);

endmodule

/* gf_fermat_div.sv */
`timescale 1ns/1ns

module gf_fermat_div import gf_pkg::*, forney_pkg::*; (
	input logic clk,
	input logic rst,
	input logic num_valid,
	output logic num_ready,
	input gf_elem_t num,                    // Numerator, omega(x).
	input logic den_valid,
	output logic den_ready,
	input gf_elem_t den,                    // Denominator, lambda'(x).
	output logic out_valid,
	input logic out_ready,
	output gf_elem_t magnitude,             // num / den.
	output logic div_zero                   // den was zero.
);

	logic busy;                             // Inverse being built.
	logic idle;
	logic accept;                           // Joint transfer of num and den.
	logic [DIV_CNT_W-1:0] cnt;              // Multiply steps done.
	gf_elem_t sq_in;
	gf_elem_t sq_out;
	gf_elem_t sq_q;                         // den^(2^k).
	gf_elem_t acc_q;                        // Partial product of the squares.
	gf_elem_t mult_b;
	gf_elem_t prod;
	gf_elem_t num_q;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Handshake.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Both sides move together, so each ready waits on the other valid.
	assign idle = !busy && !out_valid;
	assign num_ready = idle && den_valid;
	assign den_ready = idle && num_valid;
	assign accept = idle && num_valid && den_valid;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Fermat inverse den^-1 = den^254 = den^2 * den^4 * ... * den^128.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign sq_in = busy ? sq_q : den;       // First square comes straight from the input.

	gf_mult sq_mult (.a(sq_in), .b(sq_in), .p(sq_out));

	// Once the inverse is complete the second operand becomes the numerator.
	assign mult_b = out_valid ? num_q : sq_q;

	gf_mult acc_mult (.a(acc_q), .b(mult_b), .p(prod));

	assign magnitude = prod;                // A zero den gives a zero inverse and product.

	// Datapath.
	always_ff @(posedge clk) begin
		if (accept) begin
			sq_q <= sq_out;                         // den^2.
			acc_q <= GF_ONE;
			num_q <= num;
		end else if (busy) begin
			sq_q <= sq_out;                         // Next square.
			acc_q <= prod;                          // Fold in current square.
		end
	end

	// Step control.
	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			out_valid <= 1'b0;
			cnt <= '0;
			div_zero <= 1'b0;
		end else if (accept) begin
			busy <= 1'b1;
			cnt <= '0;
			div_zero <= (den == GF_ZERO);           // Flag travels with the item.
		end else if (busy) begin
			if (cnt == DIV_CNT_W'(DIV_CYCLES - 2)) begin
				busy <= 1'b0;                   // Seventh multiply leaves den^254.
				out_valid <= 1'b1;
			end else begin
				cnt <= cnt + DIV_CNT_W'(1);
			end
		end else if (out_valid && out_ready) begin
			out_valid <= 1'b0;
		end
	end

endmodule

/* poly_eval.sv */
`timescale 1ns/1ns

module poly_eval import gf_pkg::*; #(
	parameter int N_COEF = 4,               // Number of coefficients.
	parameter int SPACING = 1               // 2 evaluates odd derivative terms at point^2.
) (
	input logic clk,
	input logic rst,
	input logic in_valid,
	output logic in_ready,
	input gf_elem_t point,                  // Evaluation point.
	input gf_elem_t coef [N_COEF],          // Index N_COEF-1 is the highest power.
	output logic out_valid,
	input logic out_ready,
	output gf_elem_t result
);

	typedef logic [(N_COEF > 1 ? $clog2(N_COEF) : 1)-1:0] step_t;

	logic busy;                             // Horner steps still running.
	logic accept;                           // Input transfer this cycle.
	step_t step;                            // Index of the next coefficient.
	gf_elem_t point_sq;                     // point^2.
	gf_elem_t x_eff;                        // Point as seen by Horner.
	gf_elem_t x_q;
	gf_elem_t acc;                          // Horner accumulator.
	gf_elem_t prod;                         // acc * x_q.
	gf_elem_t coef_q [N_COEF];

	// Busy from accept until the result is taken.
	assign in_ready = !busy && !out_valid;
	assign accept = in_valid && in_ready;
	assign result = acc;                    // Held once out_valid is up.

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Point selection.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	gf_mult sq_mult (.a(point), .b(point), .p(point_sq));

	assign x_eff = (SPACING == 2) ? point_sq : point;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Horner step computing acc * x + c.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	gf_mult step_mult (.a(acc), .b(x_q), .p(prod));

	// Datapath.
	always_ff @(posedge clk) begin
		if (accept) begin
			coef_q <= coef;
			x_q <= x_eff;
			acc <= coef[N_COEF-1];                  // Start at the top coefficient.
		end else if (busy) begin
			acc <= prod ^ coef_q[step];             // Addition is XOR.
		end
	end

	// Step control.
	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			out_valid <= 1'b0;
			step <= '0;
		end else if (accept) begin
			busy <= (N_COEF > 1);
			out_valid <= (N_COEF == 1);             // Constant polynomial is done at once.
			step <= step_t'((N_COEF > 1) ? N_COEF - 2 : 0);
		end else if (busy) begin
			if (step == '0) begin
				busy <= 1'b0;                   // Last step lands now.
				out_valid <= 1'b1;
			end else begin
				step <= step - step_t'(1);
			end
		end else if (out_valid && out_ready) begin
			out_valid <= 1'b0;                      // Result taken.
		end
	end

endmodule

/* gf_mult.sv */
`timescale 1ns/1ns

module gf_mult import gf_pkg::*; (
	input gf_elem_t a,          // Multiplicand, shifted by alpha.
	input gf_elem_t b,          // Multiplier, selects the terms.
	output gf_elem_t p          // Product a * b.
);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Bit parallel standard basis multiplier.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Stage i holds a * alpha^i.
	// b[i] decides whether that term joins the running sum.

	for (genvar i = 0; i < GF_M; i++) begin : g_term
		gf_elem_t shifted;      // a * alpha^i.
		gf_elem_t partial;      // Sum of the selected terms up to i.

		if (i == 0) begin : g_first
			assign shifted = a;                                     // alpha^0 term.
			assign partial = b[0] ? a : GF_ZERO;
		end else begin : g_next
			// One more alpha per stage.
			assign shifted = gf_mul_alpha(g_term[i-1].shifted);
			assign partial = g_term[i-1].partial ^ (b[i] ? shifted : GF_ZERO);
		end
	end

	assign p = g_term[GF_M-1].partial;      // Last stage holds the full product.

endmodule

/* forney_pkg.sv */
package forney_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Code level sizes for the Forney unit.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Error evaluator omega(x), omega0..omega3.
	localparam int OMEGA_N = 4;

	// Odd locator terms lambda1 and lambda3.
	// Their derivative is lambda1 + lambda3 * x^2.
	localparam int LAMBDA_N = 2;

	// Divider latency, one cycle per field bit.
	localparam int DIV_CYCLES = 8;

	// Divider step counter width.
	localparam int DIV_CNT_W = $clog2(DIV_CYCLES);

endpackage

/* gf_pkg.sv */
package gf_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// GF(2^8) in standard basis.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	localparam int GF_M = 8;                        // Bits per field element.

	// x^8 + x^4 + x^3 + x^2 + 1, the x^8 term is implied.
	localparam logic [GF_M-1:0] GF_POLY = 8'h1d;

	// Bit i holds the alpha^i coefficient.
	typedef logic [GF_M-1:0] gf_elem_t;

	localparam gf_elem_t GF_ZERO = '0;              // Additive identity.
	localparam gf_elem_t GF_ONE = 8'h01;            // alpha^0.

	// Multiply one element by alpha.
	// A shift raises every power by one; an overflow into alpha^8
	// folds back through the field polynomial.
	function automatic gf_elem_t gf_mul_alpha(input gf_elem_t a);
		gf_elem_t shifted;
		shifted = {a[GF_M-2:0], 1'b0};          // Raise each power.
		if (a[GF_M-1]) begin
			shifted = shifted ^ GF_POLY;    // Reduce alpha^8.
		end
		return shifted;
	endfunction

endpackage
